//--- common/axi_lite_pkg.sv
// AXI channel definitions for the banked memory slave
// Single-beat transfers only, so no length, burst or user fields

`default_nettype none

package axi_lite_pkg;

  // Channel widths
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [AXI_ID_W-1:0]   axi_id_t;
  typedef logic [1:0]            axi_resp_t;

  // Only response this slave ever returns
  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  // Write address
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
  } axi_aw_t;

  // Write data, one beat
  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axi_w_t;

  // Read address
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
  } axi_ar_t;

  // Write response
  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  // Read data, one beat
  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
  } axi_r_t;

endpackage

`default_nettype wire

//--- common/mem_bank_pkg.sv
// SRAM bank geometry and crossbar payload types
// Banks are interleaved on the word address

`default_nettype none

package mem_bank_pkg;

  // Bank geometry
  localparam int MEM_NUM_BANKS   = 4;
  localparam int MEM_ADDR_W      = 8;
  localparam int MEM_DATA_W      = 32;
  localparam int MEM_STRB_W      = MEM_DATA_W / 8;
  localparam int MEM_LATENCY     = 1;
  localparam int BANK_SEL_OFFSET = 2;
  localparam int BANK_SEL_W      = 2;
  // Byte address bits that reach a bank, the rest are ignored
  localparam int BYTE_ADDR_W     = BANK_SEL_OFFSET + BANK_SEL_W + MEM_ADDR_W;

  // Crossbar inputs
  localparam int NUM_PORTS = 2;
  localparam int PORT_WR   = 1;
  localparam int PORT_RD   = 0;

  typedef logic [BANK_SEL_W-1:0]        bank_sel_t;
  typedef logic [MEM_ADDR_W-1:0]        word_addr_t;
  typedef logic [MEM_DATA_W-1:0]        mem_data_t;
  typedef logic [MEM_STRB_W-1:0]        mem_strb_t;
  typedef logic [BYTE_ADDR_W-1:0]       byte_addr_t;
  typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

  // Payload carried from a decoder to a bank
  typedef struct packed {
    word_addr_t addr;
    logic       we;
    mem_data_t  wdata;
    mem_strb_t  be;
  } bank_req_t;

  // Read grant record, one per latency stage
  typedef struct packed {
    bank_sel_t sel;
    logic      valid;
  } route_t;

  // Bank index sits right above the byte offset
  function automatic bank_sel_t bank_sel_of(byte_addr_t addr);
    return addr[BANK_SEL_OFFSET +: BANK_SEL_W];
  endfunction

  // Word address inside the bank
  function automatic word_addr_t word_addr_of(byte_addr_t addr);
    return addr[BANK_SEL_OFFSET + BANK_SEL_W +: MEM_ADDR_W];
  endfunction

endpackage

`default_nettype wire

//--- logic/wr_decode.sv
// Write path front end
// Joins AW and W into one bank request and holds it until granted

`timescale 1ns/1ps
`default_nettype none

module wr_decode (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  axi_lite_pkg::axi_aw_t   aw_i,
  input  wire logic               aw_valid_i,
  input  axi_lite_pkg::axi_w_t    w_i,
  input  wire logic               w_valid_i,
  input  wire logic               grant_i,
  input  wire logic               done_i,
  output logic                    aw_ready_o,
  output logic                    w_ready_o,
  output mem_bank_pkg::bank_req_t req_o,
  output mem_bank_pkg::bank_sel_t sel_o,
  output logic                    req_valid_o,
  output axi_lite_pkg::axi_id_t   id_o
);

  import axi_lite_pkg::*;
  import mem_bank_pkg::*;

  // Slot flags, either channel may fill first
  logic    aw_full_q;
  logic    w_full_q;
  // Set once the bank took the write, held until B is accepted
  logic    granted_q;
  axi_aw_t aw_q;
  axi_w_t  w_q;

  // A slot accepts only while empty
  assign aw_ready_o = ~aw_full_q;
  assign w_ready_o  = ~w_full_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      granted_q <= 1'b0;
    end else if (done_i) begin
      // B handshake frees both slots
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      granted_q <= 1'b0;
    end else begin
      if (aw_valid_i && aw_ready_o) begin
        aw_full_q <= 1'b1;
      end
      if (w_valid_i && w_ready_o) begin
        w_full_q <= 1'b1;
      end
      if (grant_i) begin
        granted_q <= 1'b1;
      end
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (aw_valid_i && aw_ready_o) begin
      aw_q <= aw_i;
    end
    if (w_valid_i && w_ready_o) begin
      w_q <= w_i;
    end
  end

  // Joined request, upper address bits dropped by the slicing
  assign req_valid_o = aw_full_q & w_full_q & ~granted_q;
  assign sel_o       = bank_sel_of(aw_q.addr[BYTE_ADDR_W-1:0]);
  assign req_o.addr  = word_addr_of(aw_q.addr[BYTE_ADDR_W-1:0]);
  assign req_o.we    = 1'b1;
  assign req_o.wdata = w_q.data;
  assign req_o.be    = w_q.strb;
  assign id_o        = aw_q.id;

endmodule

`default_nettype wire

//--- logic/rd_decode.sv
// Read path front end
// Holds one AR and presents it as a bank read request

`timescale 1ns/1ps
`default_nettype none

module rd_decode (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  axi_lite_pkg::axi_ar_t   ar_i,
  input  wire logic               ar_valid_i,
  input  wire logic               grant_i,
  input  wire logic               done_i,
  output logic                    ar_ready_o,
  output mem_bank_pkg::bank_req_t req_o,
  output mem_bank_pkg::bank_sel_t sel_o,
  output logic                    req_valid_o,
  output axi_lite_pkg::axi_id_t   id_o
);

  import axi_lite_pkg::*;
  import mem_bank_pkg::*;

  logic    ar_full_q;
  // Bank took the read, waiting for R to be accepted
  logic    granted_q;
  axi_ar_t ar_q;

  assign ar_ready_o = ~ar_full_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ar_full_q <= 1'b0;
      granted_q <= 1'b0;
    end else if (done_i) begin
      ar_full_q <= 1'b0;
      granted_q <= 1'b0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        ar_full_q <= 1'b1;
      end
      if (grant_i) begin
        granted_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      ar_q <= ar_i;
    end
  end

  // Read request, no data and no byte enables
  assign req_valid_o = ar_full_q & ~granted_q;
  assign sel_o       = bank_sel_of(ar_q.addr[BYTE_ADDR_W-1:0]);
  assign req_o.addr  = word_addr_of(ar_q.addr[BYTE_ADDR_W-1:0]);
  assign req_o.we    = 1'b0;
  assign req_o.wdata = '0;
  assign req_o.be    = '0;
  assign id_o        = ar_q.id;

endmodule

`default_nettype wire

//--- logic/bank_xbar.sv
// Two-port to four-bank crossbar
// Round-robin per bank, the chosen port stays locked until the bank grants

`timescale 1ns/1ps
`default_nettype none

module bank_xbar (
  input  wire logic                                                  clk_i,
  input  wire logic                                                  rst_i,
  input  mem_bank_pkg::bank_req_t  [mem_bank_pkg::NUM_PORTS-1:0]     req_i,
  input  mem_bank_pkg::bank_sel_t  [mem_bank_pkg::NUM_PORTS-1:0]     sel_i,
  input  wire logic       [mem_bank_pkg::NUM_PORTS-1:0]              valid_i,
  input  wire logic       [mem_bank_pkg::MEM_NUM_BANKS-1:0]          mem_gnt_i,
  output logic            [mem_bank_pkg::NUM_PORTS-1:0]              grant_o,
  output logic            [mem_bank_pkg::MEM_NUM_BANKS-1:0]          mem_req_o,
  output mem_bank_pkg::word_addr_t [mem_bank_pkg::MEM_NUM_BANKS-1:0] mem_addr_o,
  output logic            [mem_bank_pkg::MEM_NUM_BANKS-1:0]          mem_we_o,
  output mem_bank_pkg::mem_data_t  [mem_bank_pkg::MEM_NUM_BANKS-1:0] mem_wdata_o,
  output mem_bank_pkg::mem_strb_t  [mem_bank_pkg::MEM_NUM_BANKS-1:0] mem_be_o
);

  import mem_bank_pkg::*;

  // Grant of each bank to each port
  logic [NUM_PORTS-1:0][MEM_NUM_BANKS-1:0] bank_gnt;

  for (genvar b = 0; b < MEM_NUM_BANKS; b++) begin : gen_bank
    logic [NUM_PORTS-1:0] hit;
    port_idx_t            pick;
    logic                 lock_q;
    port_idx_t            lock_port_q;
    // Port favored on the next contested cycle
    port_idx_t            prio_q;

    // Ports whose request targets this bank
    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_hit
      assign hit[p] = valid_i[p] && (sel_i[p] == bank_sel_t'(b));
    end

    always_comb begin
      if (lock_q) begin
        // Keep the offered request stable until the grant
        pick = lock_port_q;
      end else if (&hit) begin
        pick = prio_q;
      end else if (hit[PORT_WR]) begin
        pick = port_idx_t'(PORT_WR);
      end else begin
        pick = port_idx_t'(PORT_RD);
      end
    end

    assign mem_req_o[b]   = |hit;
    assign mem_addr_o[b]  = req_i[pick].addr;
    assign mem_we_o[b]    = req_i[pick].we;
    assign mem_wdata_o[b] = req_i[pick].wdata;
    assign mem_be_o[b]    = req_i[pick].be;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_gnt
      assign bank_gnt[p][b] = mem_req_o[b] & mem_gnt_i[b] & (pick == port_idx_t'(p));
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        lock_q      <= 1'b0;
        lock_port_q <= port_idx_t'(PORT_RD);
        prio_q      <= port_idx_t'(PORT_WR);
      end else if (mem_req_o[b]) begin
        if (mem_gnt_i[b]) begin
          lock_q <= 1'b0;
          // Contested grant hands priority to the other port
          if (&hit) begin
            prio_q <= ~pick;
          end
        end else begin
          // Stalled by the bank, hold the choice
          lock_q      <= 1'b1;
          lock_port_q <= pick;
        end
      end
    end
  end

  // A port targets one bank at a time, so OR over banks is its grant
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    assign grant_o[p] = |bank_gnt[p];
  end

endmodule

`default_nettype wire

//--- logic/resp_route.sv
// Response side of both paths
// Routes read data by the recorded bank and holds the B and R channels

`timescale 1ns/1ps
`default_nettype none

module resp_route (
  input  wire logic                                                  clk_i,
  input  wire logic                                                  rst_i,
  input  wire logic       [mem_bank_pkg::NUM_PORTS-1:0]              grant_i,
  input  mem_bank_pkg::bank_sel_t  [mem_bank_pkg::NUM_PORTS-1:0]     sel_i,
  input  axi_lite_pkg::axi_id_t                                      wr_id_i,
  input  axi_lite_pkg::axi_id_t                                      rd_id_i,
  input  mem_bank_pkg::mem_data_t  [mem_bank_pkg::MEM_NUM_BANKS-1:0] mem_rdata_i,
  input  wire logic                                                  b_ready_i,
  input  wire logic                                                  r_ready_i,
  output axi_lite_pkg::axi_b_t                                       b_o,
  output logic                                                       b_valid_o,
  output axi_lite_pkg::axi_r_t                                       r_o,
  output logic                                                       r_valid_o,
  output logic                                                       wr_done_o,
  output logic                                                       rd_done_o
);

  import axi_lite_pkg::*;
  import mem_bank_pkg::*;

  // Read grant records, one stage per cycle of memory latency
  route_t [MEM_LATENCY-1:0] line_q;
  route_t                   route_in;
  route_t                   route_out;

  assign route_in  = '{sel: sel_i[PORT_RD], valid: grant_i[PORT_RD]};
  assign route_out = line_q[MEM_LATENCY-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      line_q <= '0;
    end else begin
      line_q[0] <= route_in;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end
  end

  // Valid flags of the two response registers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_valid_o <= 1'b0;
      r_valid_o <= 1'b0;
    end else begin
      if (grant_i[PORT_WR]) begin
        b_valid_o <= 1'b1;
      end else if (wr_done_o) begin
        b_valid_o <= 1'b0;
      end
      // Data is on the bank bus when the record emerges
      if (route_out.valid) begin
        r_valid_o <= 1'b1;
      end else if (rd_done_o) begin
        r_valid_o <= 1'b0;
      end
    end
  end

  // Payloads load once per transaction and hold through back-pressure
  always_ff @(posedge clk_i) begin
    if (grant_i[PORT_WR]) begin
      b_o <= '{id: wr_id_i, resp: AXI_RESP_OKAY};
    end
    if (route_out.valid) begin
      r_o <= '{id: rd_id_i, data: mem_rdata_i[route_out.sel], resp: AXI_RESP_OKAY};
    end
  end

  // Completed handshakes release the decoders
  assign wr_done_o = b_valid_o & b_ready_i;
  assign rd_done_o = r_valid_o & r_ready_i;

endmodule

`default_nettype wire

//--- axi_to_banks/axi_to_banks.sv
// AXI slave onto four interleaved SRAM banks
// Separate read and write paths, each with one transaction in flight

`timescale 1ns/1ps
`default_nettype none

module axi_to_banks (
  input  wire logic                                                     clk_i,
  input  wire logic                                                     rst_i,
  // AXI slave side
  input  axi_lite_pkg::axi_aw_t                                         aw_i,
  input  wire logic                                                     aw_valid_i,
  output logic                                                          aw_ready_o,
  input  axi_lite_pkg::axi_w_t                                          w_i,
  input  wire logic                                                     w_valid_i,
  output logic                                                          w_ready_o,
  input  axi_lite_pkg::axi_ar_t                                         ar_i,
  input  wire logic                                                     ar_valid_i,
  output logic                                                          ar_ready_o,
  output axi_lite_pkg::axi_b_t                                          b_o,
  output logic                                                          b_valid_o,
  input  wire logic                                                     b_ready_i,
  output axi_lite_pkg::axi_r_t                                          r_o,
  output logic                                                          r_valid_o,
  input  wire logic                                                     r_ready_i,
  // SRAM bank side
  output logic       [mem_bank_pkg::MEM_NUM_BANKS-1:0]                  mem_req_o,
  input  wire logic  [mem_bank_pkg::MEM_NUM_BANKS-1:0]                  mem_gnt_i,
  output mem_bank_pkg::word_addr_t [mem_bank_pkg::MEM_NUM_BANKS-1:0]    mem_addr_o,
  output logic       [mem_bank_pkg::MEM_NUM_BANKS-1:0]                  mem_we_o,
  output mem_bank_pkg::mem_data_t  [mem_bank_pkg::MEM_NUM_BANKS-1:0]    mem_wdata_o,
  output mem_bank_pkg::mem_strb_t  [mem_bank_pkg::MEM_NUM_BANKS-1:0]    mem_be_o,
  input  mem_bank_pkg::mem_data_t  [mem_bank_pkg::MEM_NUM_BANKS-1:0]    mem_rdata_i
);

  import axi_lite_pkg::*;
  import mem_bank_pkg::*;

  // Crossbar inputs, indexed by PORT_WR and PORT_RD
  bank_req_t [NUM_PORTS-1:0] port_req;
  bank_sel_t [NUM_PORTS-1:0] port_sel;
  logic      [NUM_PORTS-1:0] port_valid;
  logic      [NUM_PORTS-1:0] port_grant;

  // IDs held by the decoders until their response is taken
  axi_id_t wr_id;
  axi_id_t rd_id;
  logic    wr_done;
  logic    rd_done;

  wr_decode u_wr_decode (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .aw_i        (aw_i),
    .aw_valid_i  (aw_valid_i),
    .w_i         (w_i),
    .w_valid_i   (w_valid_i),
    .grant_i     (port_grant[PORT_WR]),
    .done_i      (wr_done),
    .aw_ready_o  (aw_ready_o),
    .w_ready_o   (w_ready_o),
    .req_o       (port_req[PORT_WR]),
    .sel_o       (port_sel[PORT_WR]),
    .req_valid_o (port_valid[PORT_WR]),
    .id_o        (wr_id)
  );

  rd_decode u_rd_decode (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ar_i        (ar_i),
    .ar_valid_i  (ar_valid_i),
    .grant_i     (port_grant[PORT_RD]),
    .done_i      (rd_done),
    .ar_ready_o  (ar_ready_o),
    .req_o       (port_req[PORT_RD]),
    .sel_o       (port_sel[PORT_RD]),
    .req_valid_o (port_valid[PORT_RD]),
    .id_o        (rd_id)
  );

  bank_xbar u_bank_xbar (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (port_req),
    .sel_i       (port_sel),
    .valid_i     (port_valid),
    .mem_gnt_i   (mem_gnt_i),
    .grant_o     (port_grant),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_we_o    (mem_we_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_be_o    (mem_be_o)
  );

  // Selects stay held through the grant, so they double as the granted bank
  resp_route u_resp_route (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .grant_i     (port_grant),
    .sel_i       (port_sel),
    .wr_id_i     (wr_id),
    .rd_id_i     (rd_id),
    .mem_rdata_i (mem_rdata_i),
    .b_ready_i   (b_ready_i),
    .r_ready_i   (r_ready_i),
    .b_o         (b_o),
    .b_valid_o   (b_valid_o),
    .r_o         (r_o),
    .r_valid_o   (r_valid_o),
    .wr_done_o   (wr_done),
    .rd_done_o   (rd_done)
  );

endmodule

`default_nettype wire

//--- tests/tb_bank_mem.sv
// Behavioral model of the four SRAM banks
// Random grant stalls, fixed read latency, byte enables on writes

`timescale 1ns/1ps
`default_nettype none

module tb_bank_mem (
  input  wire logic                                                  clk_i,
  input  wire logic                                                  rst_i,
  input  wire logic       [mem_bank_pkg::MEM_NUM_BANKS-1:0]          mem_req_i,
  output logic            [mem_bank_pkg::MEM_NUM_BANKS-1:0]          mem_gnt_o,
  input  mem_bank_pkg::word_addr_t [mem_bank_pkg::MEM_NUM_BANKS-1:0] mem_addr_i,
  input  wire logic       [mem_bank_pkg::MEM_NUM_BANKS-1:0]          mem_we_i,
  input  mem_bank_pkg::mem_data_t  [mem_bank_pkg::MEM_NUM_BANKS-1:0] mem_wdata_i,
  input  mem_bank_pkg::mem_strb_t  [mem_bank_pkg::MEM_NUM_BANKS-1:0] mem_be_i,
  output mem_bank_pkg::mem_data_t  [mem_bank_pkg::MEM_NUM_BANKS-1:0] mem_rdata_o
);

  import mem_bank_pkg::*;

  mem_data_t mem [MEM_NUM_BANKS][2**MEM_ADDR_W];
  // Read data pipe, last stage drives the banks' data outputs
  mem_data_t [MEM_LATENCY-1:0][MEM_NUM_BANKS-1:0] rd_pipe;
  logic [11:0] a;

  assign mem_rdata_o = rd_pipe[MEM_LATENCY-1];

  // Fill word built from the whole byte address
  initial begin
    mem_gnt_o = '0;
    rd_pipe = '0;
    for (int b = 0; b < MEM_NUM_BANKS; b++) begin
      for (int i = 0; i < 2**MEM_ADDR_W; i++) begin
        a = {word_addr_t'(i), bank_sel_t'(b), 2'b00};
        mem[b][i] = {4'hC, a, 4'h3, ~a};
      end
    end
  end

  always @(posedge clk_i) begin
    for (int i = 1; i < MEM_LATENCY; i++) rd_pipe[i] <= rd_pipe[i-1];
    for (int b = 0; b < MEM_NUM_BANKS; b++) begin
      // Grant three cycles in four on average
      mem_gnt_o[b] <= rst_i ? 1'b0 : (($urandom % 4) != 0);
      if (!rst_i && mem_req_i[b] && mem_gnt_o[b]) begin
        if (mem_we_i[b]) begin
          for (int k = 0; k < MEM_STRB_W; k++) begin
            if (mem_be_i[b][k]) mem[b][mem_addr_i[b]][8*k +: 8] <= mem_wdata_i[b][8*k +: 8];
          end
        end else begin
          rd_pipe[0][b] <= mem[b][mem_addr_i[b]];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/axi_to_banks_chk.sv
// Handshake rules of the banked AXI slave
// Bound into every instance of the top level

`timescale 1ns/1ps
`default_nettype none

module axi_to_banks_chk (
  input  wire logic                                         clk_i,
  input  wire logic                                         rst_i,
  input  axi_lite_pkg::axi_b_t                              b_i,
  input  wire logic                                         b_valid_i,
  input  wire logic                                         b_ready_i,
  input  axi_lite_pkg::axi_r_t                              r_i,
  input  wire logic                                         r_valid_i,
  input  wire logic                                         r_ready_i,
  input  wire logic [mem_bank_pkg::MEM_NUM_BANKS-1:0]       mem_req_i,
  input  wire logic [mem_bank_pkg::MEM_NUM_BANKS-1:0]       mem_gnt_i,
  input  wire logic                                         aw_ready_i
);

  import mem_bank_pkg::*;

  // Stalled responses keep valid and payload
  b_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else $error("B changed while waiting for ready");

  r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("R changed while waiting for ready");

  // Bank request held until granted
  for (genvar b = 0; b < MEM_NUM_BANKS; b++) begin : gen_bank
    req_held: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_req_i[b] && !mem_gnt_i[b] |=> mem_req_i[b])
      else $error("Bank %0d request dropped before grant", b);
  end

  // Write path is busy while B is pending
  b_blocks_aw: assert property (@(posedge clk_i) disable iff (rst_i)
    !(b_valid_i && aw_ready_i))
    else $error("AW ready while B pending");

endmodule

bind axi_to_banks axi_to_banks_chk u_chk (
  .clk_i (clk_i), .rst_i (rst_i),
  .b_i (b_o), .b_valid_i (b_valid_o), .b_ready_i (b_ready_i),
  .r_i (r_o), .r_valid_i (r_valid_o), .r_ready_i (r_ready_i),
  .mem_req_i (mem_req_o), .mem_gnt_i (mem_gnt_i), .aw_ready_i (aw_ready_o)
);

`default_nettype wire

//--- tests/tb_axi_to_banks.sv
// Testbench for the AXI to banked SRAM slave
// Directed tests plus a random run under B and R back-pressure

`timescale 1ns/1ps
`default_nettype none

module tb_axi_to_banks;

  import axi_lite_pkg::*;
  import mem_bank_pkg::*;

  localparam int RAND_PAIRS  = 40;
  // Directed transactions plus one write and one read per random pair
  localparam int TXN_COUNT   = 17 + 2 * RAND_PAIRS;
  // Generous bound per transaction with grant stalls and back-pressure
  localparam int TIMEOUT_CYC = TXN_COUNT * 50;

  logic clk;
  logic rst;
  axi_aw_t aw;
  logic    aw_valid;
  logic    aw_ready;
  axi_w_t  w;
  logic    w_valid;
  logic    w_ready;
  axi_ar_t ar;
  logic    ar_valid;
  logic    ar_ready;
  axi_b_t  b;
  logic    b_valid;
  logic    b_ready = 1'b1;
  axi_r_t  r;
  logic    r_valid;
  logic    r_ready = 1'b1;
  logic       [MEM_NUM_BANKS-1:0] mem_req;
  logic       [MEM_NUM_BANKS-1:0] mem_gnt;
  word_addr_t [MEM_NUM_BANKS-1:0] mem_addr;
  logic       [MEM_NUM_BANKS-1:0] mem_we;
  mem_data_t  [MEM_NUM_BANKS-1:0] mem_wdata;
  mem_strb_t  [MEM_NUM_BANKS-1:0] mem_be;
  mem_data_t  [MEM_NUM_BANKS-1:0] mem_rdata;

  // Expected memory image, one byte per 12-bit byte address
  logic [7:0]  sb [0:4095];
  int          err_cnt = 0;
  int          b_cnt = 0;
  int          r_cnt = 0;
  int          wr_issued = 0;
  int          rd_issued = 0;
  int          cycle_cnt = 0;
  logic        bp_en;

  axi_to_banks UUT (
    .clk_i (clk), .rst_i (rst),
    .aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
    .w_i (w), .w_valid_i (w_valid), .w_ready_o (w_ready),
    .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
    .b_o (b), .b_valid_o (b_valid), .b_ready_i (b_ready),
    .r_o (r), .r_valid_o (r_valid), .r_ready_i (r_ready),
    .mem_req_o (mem_req), .mem_gnt_i (mem_gnt), .mem_addr_o (mem_addr),
    .mem_we_o (mem_we), .mem_wdata_o (mem_wdata), .mem_be_o (mem_be),
    .mem_rdata_i (mem_rdata)
  );

  tb_bank_mem u_mem (
    .clk_i (clk), .rst_i (rst),
    .mem_req_i (mem_req), .mem_gnt_o (mem_gnt), .mem_addr_i (mem_addr),
    .mem_we_i (mem_we), .mem_wdata_i (mem_wdata), .mem_be_i (mem_be),
    .mem_rdata_o (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Response counters, ready throttling and watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (b_valid && b_ready) b_cnt <= b_cnt + 1;
    if (r_valid && r_ready) r_cnt <= r_cnt + 1;
    b_ready <= bp_en ? (($urandom % 3) == 0) : 1'b1;
    r_ready <= bp_en ? (($urandom % 3) == 0) : 1'b1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: tests still running after %0d cycles", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  // Same fill rule as the memory model, derived from the full byte address
  task automatic fill_scoreboard();
    logic [11:0] a;
    axi_data_t   word;
    for (int i = 0; i < 4096; i += 4) begin
      a = 12'(i);
      word = {4'hC, a, 4'h3, ~a};
      for (int k = 0; k < 4; k++) sb[i + k] = word[8*k +: 8];
    end
  endtask

  function automatic axi_data_t sb_word(axi_addr_t addr);
    return {sb[{addr[11:2], 2'd3}], sb[{addr[11:2], 2'd2}],
            sb[{addr[11:2], 2'd1}], sb[{addr[11:2], 2'd0}]};
  endfunction

  // One-bit status output against its expected level
  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s exp %b got %b", $time, name, exp, got);
    end
  endtask

  // Idle state right after reset release
  task automatic check_idle();
    check_bit("aw_ready_o", aw_ready, 1'b1);
    check_bit("w_ready_o", w_ready, 1'b1);
    check_bit("ar_ready_o", ar_ready, 1'b1);
    check_bit("b_valid_o", b_valid, 1'b0);
    check_bit("r_valid_o", r_valid, 1'b0);
    if (mem_req !== '0) begin
      err_cnt++;
      $display("ERR %0t mem_req_o exp %h got %h", $time, '0, mem_req);
    end
  endtask

  task automatic send_aw(axi_addr_t addr, axi_id_t id);
    aw <= '{id: id, addr: addr};
    aw_valid <= 1'b1;
    @(posedge clk);
    while (!aw_ready) @(posedge clk);
    aw_valid <= 1'b0;
  endtask

  task automatic send_w(axi_data_t data, axi_strb_t strb);
    w <= '{data: data, strb: strb};
    w_valid <= 1'b1;
    @(posedge clk);
    while (!w_ready) @(posedge clk);
    w_valid <= 1'b0;
  endtask

  // Order 0 sends AW and W together, 1 sends W first, 2 sends AW first
  task automatic write_txn(axi_addr_t addr, axi_data_t data, axi_strb_t strb,
                           axi_id_t id, int order);
    axi_b_t held;
    logic   seen;
    seen = 1'b0;
    held = '0;
    wr_issued++;
    case (order)
      0: fork
        send_aw(addr, id);
        send_w(data, strb);
      join
      1: begin
        send_w(data, strb);
        send_aw(addr, id);
      end
      default: begin
        send_aw(addr, id);
        send_w(data, strb);
      end
    endcase
    // B must stay valid and unchanged until accepted
    do begin
      @(posedge clk);
      // Both slots stay taken until the B handshake
      check_bit("aw_ready_o", aw_ready, 1'b0);
      check_bit("w_ready_o", w_ready, 1'b0);
      if (seen && !b_valid) begin
        err_cnt++;
        $display("B valid dropped before ready at %0t", $time);
      end
      if (seen && b_valid && (b !== held)) begin
        err_cnt++;
        $display("ERR %0t b_o exp %h got %h", $time, held, b);
      end
      if (b_valid && !seen) begin
        seen = 1'b1;
        held = b;
      end
    end while (!(b_valid && b_ready));
    if (b.id !== id) begin
      err_cnt++;
      $display("ERR %0t b_o.id exp %h got %h", $time, id, b.id);
    end
    if (b.resp !== AXI_RESP_OKAY) begin
      err_cnt++;
      $display("ERR %0t b_o.resp exp %h got %h", $time, AXI_RESP_OKAY, b.resp);
    end
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) sb[{addr[11:2], 2'(i)}] = data[8*i +: 8];
    end
  endtask

  task automatic read_txn(axi_addr_t addr, axi_id_t id);
    axi_data_t exp;
    axi_r_t    held;
    logic      seen;
    exp = sb_word(addr);
    seen = 1'b0;
    held = '0;
    rd_issued++;
    ar <= '{id: id, addr: addr};
    ar_valid <= 1'b1;
    @(posedge clk);
    while (!ar_ready) @(posedge clk);
    ar_valid <= 1'b0;
    do begin
      @(posedge clk);
      // Read path takes no new AR until R is accepted
      check_bit("ar_ready_o", ar_ready, 1'b0);
      if (seen && !r_valid) begin
        err_cnt++;
        $display("R valid dropped before ready at %0t", $time);
      end
      if (seen && r_valid && (r !== held)) begin
        err_cnt++;
        $display("ERR %0t r_o exp %h got %h", $time, held, r);
      end
      if (r_valid && !seen) begin
        seen = 1'b1;
        held = r;
      end
    end while (!(r_valid && r_ready));
    if (r.data !== exp) begin
      err_cnt++;
      $display("ERR %0t r_o.data exp %h got %h", $time, exp, r.data);
    end
    if (r.id !== id) begin
      err_cnt++;
      $display("ERR %0t r_o.id exp %h got %h", $time, id, r.id);
    end
    if (r.resp !== AXI_RESP_OKAY) begin
      err_cnt++;
      $display("ERR %0t r_o.resp exp %h got %h", $time, AXI_RESP_OKAY, r.resp);
    end
  endtask

  task automatic test_write_read();
    write_txn(32'h0000_0104, 32'hDEAD_BEEF, 4'hF, 4'h3, 0);
    read_txn(32'h0000_0104, 4'h5);
  endtask

  // Untouched bytes keep the fill pattern or the earlier write
  task automatic test_partial_strobe();
    write_txn(32'h0000_0208, 32'h1122_3344, 4'b0101, 4'h1, 0);
    read_txn(32'h0000_0208, 4'h2);
    write_txn(32'h0000_0208, 32'hAABB_CCDD, 4'b1000, 4'h4, 0);
    read_txn(32'h0000_0208, 4'h6);
  endtask

  // Bits above 11 never reach a bank
  task automatic test_alias();
    write_txn(32'hABC0_0310, 32'h0BAD_F00D, 4'hF, 4'h7, 0);
    read_txn(32'h0000_0310, 4'h8);
    read_txn(32'h7000_0310, 4'h9);
  endtask

  task automatic test_parallel();
    // Same bank 0, different words
    fork
      write_txn(32'h0000_0020, 32'h5555_AAAA, 4'hF, 4'hA, 0);
      read_txn(32'h0000_0030, 4'hB);
    join
    // Bank 1 against bank 2
    fork
      write_txn(32'h0000_0044, 32'h1357_9BDF, 4'hF, 4'hC, 0);
      read_txn(32'h0000_0048, 4'hD);
    join
  endtask

  task automatic test_channel_order();
    write_txn(32'h0000_0400, 32'hCAFE_0001, 4'hF, 4'hE, 1);
    read_txn(32'h0000_0400, 4'h0);
    write_txn(32'h0000_040C, 32'hCAFE_0002, 4'hF, 4'hF, 2);
    read_txn(32'h0000_040C, 4'h1);
  endtask

  // Random pairs, read and write never share a word
  task automatic test_backpressure();
    axi_addr_t wa;
    axi_addr_t ra;
    bp_en <= 1'b1;
    for (int n = 0; n < RAND_PAIRS; n++) begin
      wa = $urandom;
      ra = $urandom;
      if (ra[11:2] == wa[11:2]) ra[4] = ~ra[4];
      fork
        write_txn(wa, $urandom, axi_strb_t'($urandom), axi_id_t'($urandom), n % 3);
        read_txn(ra, axi_id_t'($urandom));
      join
    end
    bp_en <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h243c_f87c));
    rst <= 1'b1;
    aw <= '0;
    aw_valid <= 1'b0;
    w <= '0;
    w_valid <= 1'b0;
    ar <= '0;
    ar_valid <= 1'b0;
    bp_en <= 1'b0;
    fill_scoreboard();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_idle();
    test_write_read();
    test_partial_strobe();
    test_alias();
    test_parallel();
    test_channel_order();
    test_backpressure();
    // Let the counters settle before comparing
    repeat (4) @(posedge clk);
    if (b_cnt != wr_issued) begin
      err_cnt++;
      $display("ERR %0t b_count exp %0d got %0d", $time, wr_issued, b_cnt);
    end
    if (r_cnt != rd_issued) begin
      err_cnt++;
      $display("ERR %0t r_count exp %0d got %0d", $time, rd_issued, r_cnt);
    end
    $display("Done: %0d errors, %0d B and %0d R responses", err_cnt, b_cnt, r_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
common/axi_lite_pkg.sv
common/mem_bank_pkg.sv
logic/wr_decode.sv
logic/rd_decode.sv
logic/bank_xbar.sv
logic/resp_route.sv
axi_to_banks/axi_to_banks.sv
tests/tb_bank_mem.sv
tests/axi_to_banks_chk.sv
tests/tb_axi_to_banks.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI bank slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_axi_to_banks -f compile.f -Mdir obj_dir -o sim_axi_to_banks
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_axi_to_banks > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
exit 1
